// File: video_pkg.sv
package video_pkg;

   // Block grid of the mosaic.
   localparam int unsigned HBLKS = 8;
   localparam int unsigned VBLKS = 6;

   // Size of one block in pixels.
   localparam int unsigned BLK_W = 4;
   localparam int unsigned BLK_H = 4;
   localparam int unsigned BLK_PIXELS = BLK_W * BLK_H;

   // Block column and block row of a pixel.
   typedef logic [$clog2(HBLKS)-1:0] hblk_t;
   typedef logic [$clog2(VBLKS)-1:0] vblk_t;

   // Pixel position inside a block line, and line position inside a block.
   typedef logic [$clog2(BLK_W)-1:0] px_t;
   typedef logic [$clog2(BLK_H)-1:0] ln_t;

   // Red in bits 23:16, green in 15:8, blue in 7:0.
   typedef logic [23:0] rgb_t;

endpackage

// File: luma_pkg.sv
package luma_pkg;

   // Wide enough for BLK_PIXELS * 255 * 512 with a bit to spare.
   localparam int unsigned ACC_W = 22;

   typedef logic [ACC_W-1:0] acc_t;

   // The luminance weights add up to 512.
   localparam acc_t W_RED = acc_t'(109);
   localparam acc_t W_GREEN = acc_t'(366);
   localparam acc_t W_BLUE = acc_t'(37);

   // Average weighted luminance of 128 over a whole block.
   localparam acc_t THRES = acc_t'(video_pkg::BLK_PIXELS * 128 * 512);

endpackage

// File: block_tracker.sv
`timescale 1ns/1ps

module block_tracker (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic             vs_i,
   input  logic             de_i,
   output video_pkg::hblk_t col_o,
   output video_pkg::vblk_t row_o,
   output logic             blk_end_o,
   output logic             row_end_o,
   output logic             frame_end_o
);
   import video_pkg::*;

   px_t   px_q;
   hblk_t col_q;
   ln_t   ln_q;
   vblk_t row_q;
   logic  de_q;
   logic  line_end;
   logic  last_px;
   logic  last_ln;

   assign line_end = de_q && !de_i; // First blanking cycle of a line.
   assign last_px = (px_q == px_t'(BLK_W - 1));
   assign last_ln = (ln_q == ln_t'(BLK_H - 1));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         de_q <= 1'b0;
      end else begin
         de_q <= de_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || vs_i) begin
         px_q <= '0;
         col_q <= '0;
         ln_q <= '0;
         row_q <= '0;
      end else if (de_i) begin
         if (last_px) begin
            px_q <= '0;
            col_q <= (col_q == hblk_t'(HBLKS - 1)) ? '0 : col_q + 1'b1;
         end else begin
            px_q <= px_q + 1'b1;
         end
      end else if (line_end) begin
         px_q <= '0;
         col_q <= '0;
         if (last_ln) begin
            ln_q <= '0;
            row_q <= (row_q == vblk_t'(VBLKS - 1)) ? '0 : row_q + 1'b1;
         end else begin
            ln_q <= ln_q + 1'b1;
         end
      end
   end

   // Counters already point at the pixel on de_i, so the outputs are live.
   assign col_o = col_q;
   assign row_o = row_q;

   assign blk_end_o = de_i && last_px && last_ln;
   assign row_end_o = line_end && last_ln;
   assign frame_end_o = row_end_o && (row_q == vblk_t'(VBLKS - 1)); // Bottom row done.

endmodule

// File: blk_luma_acc.sv
`timescale 1ns/1ps

module blk_luma_acc (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic             de_i,
   input  video_pkg::rgb_t  pix_i,
   input  video_pkg::hblk_t col_i,
   input  logic             blk_end_i,
   input  logic             row_end_i,
   output logic             bit_valid_o,
   output video_pkg::hblk_t bit_col_o,
   output logic             bit_o
);
   import video_pkg::*;
   import luma_pkg::*;

   acc_t  sum_q [HBLKS];

   // Stage one holds the weighted pixel and the stored sum of its column.
   logic  de_q1;
   logic  blk_end_q1;
   logic  row_end_q1;
   hblk_t col_q1;
   acc_t  wl_q1;
   acc_t  rd_q1;

   // Stage two holds the updated sum.
   logic  de_q2;
   logic  blk_end_q2;
   logic  row_end_q2;
   hblk_t col_q2;
   acc_t  sum_q2;

   acc_t  base;
   logic  fwd;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         de_q1 <= 1'b0;
         blk_end_q1 <= 1'b0;
         row_end_q1 <= 1'b0;
         de_q2 <= 1'b0;
         blk_end_q2 <= 1'b0;
         row_end_q2 <= 1'b0;
         bit_valid_o <= 1'b0;
      end else begin
         de_q1 <= de_i;
         blk_end_q1 <= blk_end_i;
         row_end_q1 <= row_end_i;
         de_q2 <= de_q1;
         blk_end_q2 <= blk_end_q1;
         row_end_q2 <= row_end_q1;
         bit_valid_o <= blk_end_q2;
      end
   end

   always_ff @(posedge clk_i) begin
      col_q1 <= col_i;
      rd_q1 <= sum_q[col_i];
      wl_q1 <= W_RED * pix_i[23:16] + W_GREEN * pix_i[15:8] + W_BLUE * pix_i[7:0];
      col_q2 <= col_q1;
      sum_q2 <= base + wl_q1;
      bit_col_o <= col_q2;
      bit_o <= (sum_q2 >= THRES);
   end

   // The previous pixel of the same column has not reached sum_q yet.
   assign fwd = de_q2 && (col_q2 == col_q1);
   assign base = fwd ? sum_q2 : rd_q1;

   // The delayed row end lands after the last write of the row.
   always_ff @(posedge clk_i) begin
      if (reset_i || row_end_q2) begin
         for (int i = 0; i < HBLKS; i++) begin
            sum_q[i] <= '0;
         end
      end else if (de_q2) begin
         sum_q[col_q2] <= sum_q2;
      end
   end

endmodule

// File: blk_bitmap.sv
`timescale 1ns/1ps

module blk_bitmap (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic             bit_valid_i,
   input  video_pkg::hblk_t bit_col_i,
   input  logic             bit_i,
   input  logic             row_end_i,
   input  video_pkg::vblk_t row_i,
   input  logic             frame_end_i,

   input  logic             rclk_i,
   input  logic             rreset_i,
   input  logic             rvs_i,
   input  logic             rde_i,
   input  video_pkg::hblk_t rcol_i,
   input  video_pkg::vblk_t rrow_i,
   output logic             rx_o
);
   import video_pkg::*;

   logic [HBLKS-1:0]            row_bits_q;
   logic [VBLKS-1:0][HBLKS-1:0] bitmap_q;
   logic [VBLKS-1:0][HBLKS-1:0] handoff_q;
   logic [VBLKS-1:0][HBLKS-1:0] rd1_q;
   logic [VBLKS-1:0][HBLKS-1:0] rd2_q;

   vblk_t      row_sel_q;
   logic [2:0] row_end_d;
   logic [3:0] frame_end_d;

   // Row end arrives before the bit of the last block, so it is delayed.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         row_end_d <= '0;
         frame_end_d <= '0;
         row_sel_q <= '0;
      end else begin
         row_end_d <= {row_end_d[1:0], row_end_i};
         frame_end_d <= {frame_end_d[2:0], frame_end_i};
         if (row_end_i) begin
            row_sel_q <= row_i; // Tracker moves to the next row right after.
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         row_bits_q <= '0;
         bitmap_q <= '0;
         handoff_q <= '0;
      end else begin
         if (bit_valid_i) begin
            row_bits_q[bit_col_i] <= bit_i;
         end
         if (row_end_d[2]) begin
            bitmap_q[row_sel_q] <= row_bits_q;
         end
         if (frame_end_d[3]) begin
            handoff_q <= bitmap_q; // One cycle after the bottom row is written.
         end
      end
   end

   // Read frame starts are kept clear of write frame ends.
   always_ff @(posedge rclk_i) begin
      if (rreset_i) begin
         rd1_q <= '0;
         rd2_q <= '0;
      end else if (rvs_i) begin
         rd1_q <= handoff_q;
         rd2_q <= rd1_q;
      end
   end

   always_ff @(posedge rclk_i) begin
      if (rreset_i) begin
         rx_o <= 1'b0;
      end else begin
         rx_o <= rde_i ? rd2_q[rrow_i][rcol_i] : 1'b0;
      end
   end

endmodule

// File: blk_mosaic_top.sv
`timescale 1ns/1ps

module blk_mosaic_top (
   input  logic            clk_i,
   input  logic            reset_i,
   input  logic            vs_i,
   input  logic            de_i,
   input  video_pkg::rgb_t pix_i,

   input  logic            rclk_i,
   input  logic            rreset_i,
   input  logic            rvs_i,
   input  logic            rde_i,
   output logic            rx_o
);
   import video_pkg::*;

   hblk_t wr_col;
   vblk_t wr_row;
   logic  wr_blk_end;
   logic  wr_row_end;
   logic  wr_frame_end;

   logic  bit_valid;
   hblk_t bit_col;
   logic  blk_bit;

   hblk_t rd_col;
   vblk_t rd_row;

   block_tracker i_wr_tracker (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .vs_i        (vs_i),
      .de_i        (de_i),
      .col_o       (wr_col),
      .row_o       (wr_row),
      .blk_end_o   (wr_blk_end),
      .row_end_o   (wr_row_end),
      .frame_end_o (wr_frame_end)
   );

   blk_luma_acc i_luma_acc (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .de_i        (de_i),
      .pix_i       (pix_i),
      .col_i       (wr_col),
      .blk_end_i   (wr_blk_end),
      .row_end_i   (wr_row_end),
      .bit_valid_o (bit_valid),
      .bit_col_o   (bit_col),
      .bit_o       (blk_bit)
   );

   blk_bitmap i_bitmap (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .bit_valid_i (bit_valid),
      .bit_col_i   (bit_col),
      .bit_i       (blk_bit),
      .row_end_i   (wr_row_end),
      .row_i       (wr_row),
      .frame_end_i (wr_frame_end),
      .rclk_i      (rclk_i),
      .rreset_i    (rreset_i),
      .rvs_i       (rvs_i),
      .rde_i       (rde_i),
      .rcol_i      (rd_col),
      .rrow_i      (rd_row),
      .rx_o        (rx_o)
   );

   // Only the position is needed on the read side.
   block_tracker i_rd_tracker (
      .clk_i       (rclk_i),
      .reset_i     (rreset_i),
      .vs_i        (rvs_i),
      .de_i        (rde_i),
      .col_o       (rd_col),
      .row_o       (rd_row),
      .blk_end_o   (),
      .row_end_o   (),
      .frame_end_o ()
   );

endmodule

// File: tb_blk_mosaic.sv
`timescale 1ns/1ps

module tb_blk_mosaic;
   import video_pkg::*;

   localparam int FRAME_W = HBLKS * BLK_W;
   localparam int FRAME_H = VBLKS * BLK_H;
   localparam int H_BLANK = 4;
   localparam int V_BLANK = 8;
   localparam int FRAME_CYC = 2 + FRAME_H * (FRAME_W + H_BLANK) + V_BLANK;
   localparam int N_WR_FRAMES = 8;
   localparam int N_RD_FRAMES = 18;
   localparam int TIMEOUT_NS = 3 * (N_WR_FRAMES * FRAME_CYC * 10 + N_RD_FRAMES * FRAME_CYC * 14);

   // The weights of the luminance rule add up to 512.
   localparam int LUMA_R = 109;
   localparam int LUMA_G = 366;
   localparam int LUMA_B = 37;
   localparam int LIMIT = BLK_PIXELS * 128 * 512; // Average luminance of 128.

   localparam rgb_t WHITE = 24'hFFFFFF;
   localparam rgb_t BLACK = 24'h000000;
   localparam rgb_t GREY_128 = 24'h808080;
   localparam rgb_t GREY_127 = 24'h7F7F7F;

   typedef logic [VBLKS-1:0][HBLKS-1:0] bits_t;

   logic clk_i;
   logic reset_i;
   logic vs_i;
   logic de_i;
   rgb_t pix_i;
   logic rclk_i;
   logic rreset_i;
   logic rvs_i;
   logic rde_i;
   logic rx_o;

   rgb_t        frame_pix [FRAME_H][FRAME_W];
   logic        rd_pix [FRAME_H][FRAME_W];
   bits_t       exp_bits;
   bits_t       old_bits;
   int unsigned seed_val;

   blk_mosaic_top i_dut (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .vs_i     (vs_i),
      .de_i     (de_i),
      .pix_i    (pix_i),
      .rclk_i   (rclk_i),
      .rreset_i (rreset_i),
      .rvs_i    (rvs_i),
      .rde_i    (rde_i),
      .rx_o     (rx_o)
   );

   always #5 clk_i = ~clk_i;
   always #7 rclk_i = ~rclk_i;

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("error %s: expected %b actual %b", name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_row(input string name, input int row,
                            input logic [HBLKS-1:0] expected, input logic [HBLKS-1:0] actual);
      if (actual !== expected) begin
         $display("error %s: block row %0d expected %b actual %b", name, row, expected, actual);
         abort_run();
      end
   endtask

   // Reference model of one bit per block.
   function automatic bits_t block_bits();
      bits_t bits;
      int    sum;
      rgb_t  p;
      bits = '0;
      for (int r = 0; r < VBLKS; r++) begin
         for (int c = 0; c < HBLKS; c++) begin
            sum = 0;
            for (int y = 0; y < BLK_H; y++) begin
               for (int x = 0; x < BLK_W; x++) begin
                  p = frame_pix[r * BLK_H + y][c * BLK_W + x];
                  sum = sum + LUMA_R * p[23:16] + LUMA_G * p[15:8] + LUMA_B * p[7:0];
               end
            end
            bits[r][c] = (sum >= LIMIT);
         end
      end
      return bits;
   endfunction

   task automatic fill_by_block(input bits_t pattern, input rgb_t one_pix, input rgb_t zero_pix);
      for (int y = 0; y < FRAME_H; y++) begin
         for (int x = 0; x < FRAME_W; x++) begin
            frame_pix[y][x] = pattern[y / BLK_H][x / BLK_W] ? one_pix : zero_pix;
         end
      end
   endtask

   task automatic fill_random();
      logic [31:0] r;
      for (int y = 0; y < FRAME_H; y++) begin
         for (int x = 0; x < FRAME_W; x++) begin
            r = $urandom();
            frame_pix[y][x] = r[23:0];
         end
      end
   endtask

   task automatic send_frame();
      @(negedge clk_i);
      vs_i = 1'b1;
      @(negedge clk_i);
      vs_i = 1'b0;
      for (int y = 0; y < FRAME_H; y++) begin
         for (int x = 0; x < FRAME_W; x++) begin
            de_i = 1'b1;
            pix_i = frame_pix[y][x];
            @(negedge clk_i);
         end
         de_i = 1'b0;
         pix_i = '0;
         repeat (H_BLANK) @(negedge clk_i);
      end
      repeat (V_BLANK) @(negedge clk_i); // Hand-off buffer settles here.
   endtask

   // The mosaic bit of a pixel shows up one read clock after it.
   task automatic read_frame(input string name);
      @(negedge rclk_i);
      rvs_i = 1'b1;
      @(negedge rclk_i);
      rvs_i = 1'b0;
      for (int y = 0; y < FRAME_H; y++) begin
         for (int x = 0; x < FRAME_W; x++) begin
            rde_i = 1'b1;
            @(negedge rclk_i);
            rd_pix[y][x] = rx_o;
         end
         rde_i = 1'b0;
         repeat (H_BLANK) begin
            @(negedge rclk_i);
            check_bit(name, 1'b0, rx_o);
         end
      end
      repeat (V_BLANK) begin
         @(negedge rclk_i);
         check_bit(name, 1'b0, rx_o);
      end
   endtask

   task automatic verify_frame(input string name, input bits_t expected);
      logic [HBLKS-1:0] act;
      for (int r = 0; r < VBLKS; r++) begin
         for (int c = 0; c < HBLKS; c++) begin
            act[c] = rd_pix[r * BLK_H][c * BLK_W];
         end
         check_row(name, r, expected[r], act);
      end
      for (int y = 0; y < FRAME_H; y++) begin
         for (int x = 0; x < FRAME_W; x++) begin
            check_bit(name, expected[y / BLK_H][x / BLK_W], rd_pix[y][x]);
         end
      end
   endtask

   // The first read frame still shows the previous bitmap.
   task automatic write_and_show(input string name);
      old_bits = exp_bits;
      send_frame();
      exp_bits = block_bits();
      read_frame({name, " first read"});
      verify_frame({name, " first read"}, old_bits);
      read_frame({name, " second read"});
      verify_frame({name, " second read"}, exp_bits);
   endtask

   task automatic test_reset_idle();
      exp_bits = '0;
      read_frame("reset_idle");
      verify_frame("reset_idle", '0);
   endtask

   task automatic test_white_black();
      fill_by_block('1, WHITE, BLACK);
      write_and_show("all_white");
      fill_by_block('0, WHITE, BLACK);
      write_and_show("all_black");
   endtask

   task automatic test_threshold();
      bits_t pattern;
      pattern = 48'h5A3C_96E1_0FF0;
      fill_by_block(pattern, GREY_128, GREY_127);
      write_and_show("grey_threshold");
      fill_by_block(~pattern, GREY_128, GREY_127);
      write_and_show("grey_threshold_inv");
   endtask

   task automatic test_random();
      fill_random();
      write_and_show("random_a");
      fill_random();
      write_and_show("random_b");
   endtask

   task automatic test_double_buffer();
      fill_by_block(~exp_bits, WHITE, BLACK); // Every block flips.
      write_and_show("double_buffer");
      read_frame("double_buffer third read");
      verify_frame("double_buffer third read", exp_bits);
   endtask

   task automatic test_block_edges();
      bits_t pattern;
      for (int r = 0; r < VBLKS; r++) begin
         for (int c = 0; c < HBLKS; c++) begin
            pattern[r][c] = (r % 2) ^ (c % 2);
         end
      end
      fill_by_block(pattern, WHITE, BLACK);
      write_and_show("block_edges");
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      abort_run();
   end

   initial begin
      clk_i = 1'b0;
      rclk_i = 1'b0;
      reset_i = 1'b1;
      rreset_i = 1'b1;
      vs_i = 1'b0;
      de_i = 1'b0;
      pix_i = '0;
      rvs_i = 1'b0;
      rde_i = 1'b0;
      exp_bits = '0;
      old_bits = '0;
      seed_val = $urandom(82789);
      fork
         begin
            repeat (8) @(negedge clk_i);
            reset_i = 1'b0;
         end
         begin
            repeat (8) @(negedge rclk_i);
            rreset_i = 1'b0;
         end
      join
      test_reset_idle();
      test_white_black();
      test_threshold();
      test_random();
      test_double_buffer();
      test_block_edges();
      $display("Test passed");
      $finish;
   end

endmodule

// File: verilog.f
video_pkg.sv
luma_pkg.sv
block_tracker.sv
blk_luma_acc.sv
blk_bitmap.sv
blk_mosaic_top.sv
tb_blk_mosaic.sv

// File: Bender.yml
package:
  name: blk_mosaic

sources:
  - video_pkg.sv
  - luma_pkg.sv
  - block_tracker.sv
  - blk_luma_acc.sv
  - blk_bitmap.sv
  - blk_mosaic_top.sv
  - target: test
    files:
      - tb_blk_mosaic.sv
